// File: rtl/pkt_sched_params.svh
// pkt_sched_params: sizing constants for the packet scheduling core
`ifndef PKT_SCHED_PARAMS_SVH
`define PKT_SCHED_PARAMS_SVH

// cores served by the scheduler
`define PS_CORE_COUNT 16

// receive slots per core
`define PS_SLOT_COUNT 8

// completion message width
`define PS_MSG_WIDTH 64

// per-core message fifo holds 2**3 entries
`define PS_FIFO_ADDR_SIZE 3

`define PS_CORE_NO_WIDTH ($clog2(`PS_CORE_COUNT))
`define PS_SLOT_NO_WIDTH ($clog2(`PS_SLOT_COUNT))

`endif

// File: rtl/pkt_sched_pkg.sv
// pkt_sched_pkg: shared types for descriptors, core messages and slot bitmaps
`include "pkt_sched_params.svh"

package pkt_sched_pkg;

  // core index
  typedef logic [`PS_CORE_NO_WIDTH-1:0] core_no_t;

  // slot index within one core
  typedef logic [`PS_SLOT_NO_WIDTH-1:0] slot_no_t;

  // receive descriptor, core number on top and slot number below
  typedef logic [`PS_CORE_NO_WIDTH+`PS_SLOT_NO_WIDTH-1:0] desc_t;

  // completion message, low bits name the released slot
  typedef logic [`PS_MSG_WIDTH-1:0] msg_t;

  // one bit per slot, set when free
  typedef logic [`PS_SLOT_COUNT-1:0] slot_map_t;

endpackage

// File: rtl/core_msg_fifo.sv
// core_msg_fifo: small synchronous FIFO buffering one core's completion messages
`timescale 1ns/1ps

module core_msg_fifo #(
  parameter int WIDTH     = 64,
  parameter int ADDR_SIZE = 3
) (
  input  logic             logic_clk,
  input  logic             arst_n,
  input  logic [WIDTH-1:0] wr_data,
  input  logic             wr_en,
  input  logic             rd_en,
  output logic [WIDTH-1:0] rd_data,
  output logic             empty,
  output logic             full
);

  localparam int DEPTH = 1 << ADDR_SIZE;

  logic [WIDTH-1:0]     mem [DEPTH];
  logic [ADDR_SIZE-1:0] wr_ptr;
  logic [ADDR_SIZE-1:0] rd_ptr;
  logic [ADDR_SIZE:0]   count;
  logic                 do_wr;
  logic                 do_rd;

  // count never exceeds DEPTH, so the top bit alone means full
  assign empty   = (count == '0);
  assign full    = count[ADDR_SIZE];
  assign do_wr   = wr_en && !full;
  assign do_rd   = rd_en && !empty;
  assign rd_data = mem[rd_ptr];

  always_ff @(posedge logic_clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  always_ff @(posedge logic_clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: rtl/core_msg_arbiter.sv
// core_msg_arbiter: per-core message FIFOs merged into one stream by round-robin
`timescale 1ns/1ps
`include "pkt_sched_params.svh"

module core_msg_arbiter (
  input  logic                                      logic_clk,
  input  logic                                      arst_n,
  input  pkt_sched_pkg::msg_t [`PS_CORE_COUNT-1:0] core_msg_data,
  input  logic [`PS_CORE_COUNT-1:0]                 core_msg_valid,
  output pkt_sched_pkg::msg_t                       msg_data,
  output pkt_sched_pkg::core_no_t                   msg_core_no,
  output logic                                      msg_valid,
  input  logic                                      msg_ready
);

  import pkt_sched_pkg::*;

  msg_t                      fifo_head [`PS_CORE_COUNT];
  logic [`PS_CORE_COUNT-1:0] fifo_empty;
  logic [`PS_CORE_COUNT-1:0] fifo_rd;
  core_no_t                  last_grant;
  core_no_t                  pick_no;
  logic                      pick_found;
  logic                      out_load;

  // output register free now or emptied this cycle
  assign out_load = !msg_valid || msg_ready;

  for (genvar i = 0; i < `PS_CORE_COUNT; i++) begin : g_core
    // no ready toward the cores, overflow drops inside the fifo
    core_msg_fifo #(
      .WIDTH     (`PS_MSG_WIDTH),
      .ADDR_SIZE (`PS_FIFO_ADDR_SIZE)
    ) fifo_i (
      .logic_clk (logic_clk),
      .arst_n    (arst_n),
      .wr_data   (core_msg_data[i]),
      .wr_en     (core_msg_valid[i]),
      .rd_en     (fifo_rd[i]),
      .rd_data   (fifo_head[i]),
      .empty     (fifo_empty[i]),
      .full      ()
    );

    assign fifo_rd[i] = out_load && pick_found && (pick_no == core_no_t'(i));
  end

  // first non-empty fifo after the last grant, wrapping
  always_comb begin
    int idx;
    pick_found = 1'b0;
    pick_no    = last_grant;
    for (int k = 1; k <= `PS_CORE_COUNT; k++) begin
      idx = (int'(last_grant) + k) % `PS_CORE_COUNT;
      if (!pick_found && !fifo_empty[idx]) begin
        pick_found = 1'b1;
        pick_no    = core_no_t'(idx);
      end
    end
  end

  always_ff @(posedge logic_clk or negedge arst_n) begin
    if (!arst_n) begin
      msg_valid  <= 1'b0;
      last_grant <= core_no_t'(`PS_CORE_COUNT - 1);
    end else if (out_load) begin
      msg_valid <= pick_found;
      if (pick_found) begin
        last_grant <= pick_no;
      end
    end
  end

  always_ff @(posedge logic_clk) begin
    if (out_load && pick_found) begin
      msg_data    <= fifo_head[pick_no];
      msg_core_no <= pick_no;
    end
  end

endmodule

// File: rtl/slot_tracker.sv
// slot_tracker: free-slot bookkeeping, descriptor allocation and completion output
`timescale 1ns/1ps
`include "pkt_sched_params.svh"

module slot_tracker (
  input  logic                    logic_clk,
  input  logic                    arst_n,
  input  logic                    pkt_valid,
  output logic                    pkt_ready,
  output pkt_sched_pkg::desc_t    rx_desc,
  output logic                    rx_desc_valid,
  input  logic                    rx_desc_ready,
  input  pkt_sched_pkg::msg_t     msg_data,
  input  pkt_sched_pkg::core_no_t msg_core_no,
  input  logic                    msg_valid,
  output logic                    msg_ready,
  output pkt_sched_pkg::msg_t     done_msg,
  output pkt_sched_pkg::core_no_t done_core_no,
  output logic                    done_valid,
  input  logic                    done_ready
);

  import pkt_sched_pkg::*;

  slot_map_t free_map [`PS_CORE_COUNT];
  core_no_t  last_core;
  core_no_t  alloc_core;
  slot_no_t  alloc_slot;
  logic      alloc_found;
  slot_no_t  rel_slot;
  logic      pkt_take;
  logic      msg_take;

  assign pkt_ready = alloc_found && (!rx_desc_valid || rx_desc_ready);
  assign pkt_take  = pkt_valid && pkt_ready;
  assign msg_ready = !done_valid || done_ready;
  assign msg_take  = msg_valid && msg_ready;
  assign rel_slot  = msg_data[`PS_SLOT_NO_WIDTH-1:0];

  // next core with a free slot, then its lowest free slot
  always_comb begin
    int c_idx;
    alloc_found = 1'b0;
    alloc_core  = last_core;
    alloc_slot  = '0;
    for (int k = 1; k <= `PS_CORE_COUNT; k++) begin
      c_idx = (int'(last_core) + k) % `PS_CORE_COUNT;
      if (!alloc_found && (|free_map[c_idx])) begin
        alloc_found = 1'b1;
        alloc_core  = core_no_t'(c_idx);
        for (int s = `PS_SLOT_COUNT - 1; s >= 0; s--) begin
          if (free_map[c_idx][s]) begin
            alloc_slot = slot_no_t'(s);
          end
        end
      end
    end
  end

  always_ff @(posedge logic_clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int c = 0; c < `PS_CORE_COUNT; c++) begin
        free_map[c] <= '1;
      end
      last_core     <= core_no_t'(`PS_CORE_COUNT - 1);
      rx_desc_valid <= 1'b0;
      done_valid    <= 1'b0;
    end else begin
      for (int c = 0; c < `PS_CORE_COUNT; c++) begin
        if (msg_take && msg_core_no == core_no_t'(c)) begin
          free_map[c][rel_slot] <= 1'b1;
        end
        // allocation after release, a slot handed out stays busy
        if (pkt_take && alloc_core == core_no_t'(c)) begin
          free_map[c][alloc_slot] <= 1'b0;
        end
      end
      if (pkt_take) begin
        last_core     <= alloc_core;
        rx_desc_valid <= 1'b1;
      end else if (rx_desc_ready) begin
        rx_desc_valid <= 1'b0;
      end
      if (msg_take) begin
        done_valid <= 1'b1;
      end else if (done_ready) begin
        done_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge logic_clk) begin
    if (pkt_take) begin
      rx_desc <= {alloc_core, alloc_slot};
    end
    if (msg_take) begin
      done_msg     <= msg_data;
      done_core_no <= msg_core_no;
    end
  end

endmodule

// File: rtl/pkt_sched_top.sv
// pkt_sched_top: receive-slot allocation and core completion message handling
`timescale 1ns/1ps
`include "pkt_sched_params.svh"

module pkt_sched_top (
  input  logic                                      logic_clk,
  input  logic                                      arst_n,

  // incoming packet requests
  input  logic                                      pkt_valid,
  output logic                                      pkt_ready,

  // receive descriptor toward the DMA
  output pkt_sched_pkg::desc_t                      rx_desc,
  output logic                                      rx_desc_valid,
  input  logic                                      rx_desc_ready,

  // messages from the cores, one per core
  input  pkt_sched_pkg::msg_t [`PS_CORE_COUNT-1:0] core_msg_data,
  input  logic [`PS_CORE_COUNT-1:0]                 core_msg_valid,

  // completions
  output pkt_sched_pkg::msg_t                       done_msg,
  output pkt_sched_pkg::core_no_t                   done_core_no,
  output logic                                      done_valid,
  input  logic                                      done_ready
);

  import pkt_sched_pkg::*;

  msg_t     msg_data;
  core_no_t msg_core_no;
  logic     msg_valid;
  logic     msg_ready;

  core_msg_arbiter msg_arbiter_i (
    .logic_clk      (logic_clk),
    .arst_n         (arst_n),
    .core_msg_data  (core_msg_data),
    .core_msg_valid (core_msg_valid),
    .msg_data       (msg_data),
    .msg_core_no    (msg_core_no),
    .msg_valid      (msg_valid),
    .msg_ready      (msg_ready)
  );

  slot_tracker slot_tracker_i (
    .logic_clk     (logic_clk),
    .arst_n        (arst_n),
    .pkt_valid     (pkt_valid),
    .pkt_ready     (pkt_ready),
    .rx_desc       (rx_desc),
    .rx_desc_valid (rx_desc_valid),
    .rx_desc_ready (rx_desc_ready),
    .msg_data      (msg_data),
    .msg_core_no   (msg_core_no),
    .msg_valid     (msg_valid),
    .msg_ready     (msg_ready),
    .done_msg      (done_msg),
    .done_core_no  (done_core_no),
    .done_valid    (done_valid),
    .done_ready    (done_ready)
  );

endmodule

// File: testbench/tb_pkt_sched.sv
// tb_pkt_sched checks the packet scheduling core against a reference model
`timescale 1ns/1ps
`include "pkt_sched_params.svh"

module tb_pkt_sched;

  import pkt_sched_pkg::*;

  // ample margin over 128 allocations plus the message bursts
  localparam int MAX_CYCLES = 4000;

  logic                        logic_clk;
  logic                        arst_n;
  logic                        pkt_valid;
  logic                        pkt_ready;
  desc_t                       rx_desc;
  logic                        rx_desc_valid;
  logic                        rx_desc_ready;
  msg_t [`PS_CORE_COUNT-1:0]   core_msg_data;
  logic [`PS_CORE_COUNT-1:0]   core_msg_valid;
  msg_t                        done_msg;
  core_no_t                    done_core_no;
  logic                        done_valid;
  logic                        done_ready;

  // reference model state
  slot_map_t model_map [`PS_CORE_COUNT];
  core_no_t  alloc_last;
  core_no_t  arb_last;
  desc_t     exp_desc [$];
  msg_t      exp_msg [$];
  core_no_t  exp_core [$];
  msg_t      burst_msg [`PS_CORE_COUNT];

  desc_t       last_desc;
  msg_t        held_msg;
  core_no_t    held_core;
  logic        desc_hold;
  logic        done_hold;
  logic        done_seen;
  int          acc_cnt;
  int          cycle_cnt;
  int          test_errs;
  int          pass_cnt;
  int          fail_cnt;
  string       cur_test;
  logic [31:0] rng_state;

  pkt_sched_top dut_i (
    .logic_clk      (logic_clk),
    .arst_n         (arst_n),
    .pkt_valid      (pkt_valid),
    .pkt_ready      (pkt_ready),
    .rx_desc        (rx_desc),
    .rx_desc_valid  (rx_desc_valid),
    .rx_desc_ready  (rx_desc_ready),
    .core_msg_data  (core_msg_data),
    .core_msg_valid (core_msg_valid),
    .done_msg       (done_msg),
    .done_core_no   (done_core_no),
    .done_valid     (done_valid),
    .done_ready     (done_ready)
  );

  always #2 logic_clk = ~logic_clk;

  always @(posedge logic_clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  initial begin
    wait (cycle_cnt >= MAX_CYCLES);
    $display("timeout: run stopped after %0d cycles", cycle_cnt);
    $display("SOME TESTS FAILED");
    $finish;
  end

  function automatic logic [31:0] xorshift32();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // lowest free slot of the next core with room after the last grant
  function automatic desc_t model_alloc();
    int    c;
    int    s;
    bit    hit;
    desc_t d;
    hit = 1'b0;
    d   = '0;
    for (int k = 1; k <= `PS_CORE_COUNT; k++) begin
      c = (int'(alloc_last) + k) % `PS_CORE_COUNT;
      if (!hit && model_map[c] != '0) begin
        s = 0;
        while (!model_map[c][s]) begin
          s++;
        end
        hit             = 1'b1;
        model_map[c][s] = 1'b0;
        alloc_last      = core_no_t'(c);
        d               = {core_no_t'(c), slot_no_t'(s)};
      end
    end
    return d;
  endfunction

  task automatic check_desc(input string name, input desc_t exp, input desc_t act);
    if (act !== exp) begin
      $display("ERROR %s: descriptor expected 0x%0h, actual 0x%0h", name, exp, act);
      test_errs++;
    end
  endtask

  task automatic check_msg(input string name, input msg_t exp, input msg_t act);
    if (act !== exp) begin
      $display("ERROR %s: message expected 0x%h, actual 0x%h", name, exp, act);
      test_errs++;
    end
  endtask

  task automatic check_core(input string name, input core_no_t exp, input core_no_t act);
    if (act !== exp) begin
      $display("ERROR %s: core expected %0d, actual %0d", name, exp, act);
      test_errs++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERROR %s: expected %b, actual %b", name, exp, act);
      test_errs++;
    end
  endtask

  task automatic report_problem(input string what);
    $display("%s: %s", cur_test, what);
    test_errs++;
  endtask

  // sampled just after the falling edge once outputs have settled
  always @(negedge logic_clk) begin : monitor
    #1;
    if (arst_n) begin
      if (desc_hold) begin
        check_flag({cur_test, " rx_desc_valid held"}, 1'b1, rx_desc_valid);
      end
      if (done_hold) begin
        check_flag({cur_test, " done_valid held"}, 1'b1, done_valid);
        check_msg(cur_test, held_msg, done_msg);
        check_core(cur_test, held_core, done_core_no);
      end
      if (rx_desc_valid) begin
        if (exp_desc.size() == 0) begin
          report_problem("descriptor valid when none was expected");
        end else if (rx_desc_ready) begin
          check_desc(cur_test, exp_desc.pop_front(), rx_desc);
        end else begin
          check_desc(cur_test, exp_desc[0], rx_desc);
        end
        last_desc = rx_desc;
      end
      if (done_valid && !done_seen) begin
        if (exp_msg.size() == 0) begin
          report_problem("completion appeared when none was expected");
        end else begin
          held_msg  = exp_msg.pop_front();
          held_core = exp_core.pop_front();
          check_core(cur_test, held_core, done_core_no);
          check_msg(cur_test, held_msg, done_msg);
          // slot freed on the edge that took the message
          model_map[held_core][held_msg[`PS_SLOT_NO_WIDTH-1:0]] = 1'b1;
        end
        done_seen = 1'b1;
      end
      if (done_valid && done_ready) begin
        done_seen = 1'b0;
      end
      if (pkt_valid && pkt_ready) begin
        exp_desc.push_back(model_alloc());
        acc_cnt++;
      end
      desc_hold = rx_desc_valid && !rx_desc_ready;
      done_hold = done_valid && !done_ready;
    end
  end

  task automatic start_test(input string name);
    cur_test  = name;
    test_errs = 0;
  endtask

  task automatic finish_test();
    if (test_errs == 0) begin
      $display("PASS %s", cur_test);
      pass_cnt++;
    end else begin
      $display("FAIL %s with %0d errors", cur_test, test_errs);
      fail_cnt++;
    end
  endtask

  task automatic wait_idle();
    while (exp_desc.size() != 0 || exp_msg.size() != 0) begin
      @(negedge logic_clk);
    end
  endtask

  task automatic request_packets(input int n);
    int target;
    target    = acc_cnt + n;
    pkt_valid = 1'b1;
    while (acc_cnt < target) begin
      @(negedge logic_clk);
    end
    pkt_valid = 1'b0;
  endtask

  // one message per masked core in a single cycle with completions queued in grant order
  task automatic send_burst(input logic [`PS_CORE_COUNT-1:0] mask);
    int       c;
    logic [31:0] hi;
    core_no_t from;
    for (int i = 0; i < `PS_CORE_COUNT; i++) begin
      if (mask[i]) begin
        hi               = xorshift32();
        burst_msg[i]     = {hi, xorshift32()};
        core_msg_data[i] = burst_msg[i];
      end
    end
    from = arb_last;
    for (int k = 1; k <= `PS_CORE_COUNT; k++) begin
      c = (int'(from) + k) % `PS_CORE_COUNT;
      if (mask[c]) begin
        exp_msg.push_back(burst_msg[c]);
        exp_core.push_back(core_no_t'(c));
        arb_last = core_no_t'(c);
      end
    end
    core_msg_valid = mask;
    @(negedge logic_clk);
    core_msg_valid = '0;
  endtask

  task automatic verify_reset_state();
    start_test("reset_state");
    check_flag("reset_state rx_desc_valid", 1'b0, rx_desc_valid);
    check_flag("reset_state done_valid", 1'b0, done_valid);
    check_flag("reset_state pkt_ready", 1'b1, pkt_ready);
    finish_test();
  endtask

  task automatic exhaust_slots();
    start_test("alloc_exhaust");
    request_packets(`PS_CORE_COUNT * `PS_SLOT_COUNT);
    wait_idle();
    check_flag("alloc_exhaust pkt_ready", 1'b0, pkt_ready);
    finish_test();
  endtask

  task automatic release_and_reuse();
    logic [31:0] r;
    core_no_t    c;
    desc_t       want;
    start_test("release_reuse");
    r = xorshift32();
    c = r[`PS_CORE_NO_WIDTH-1:0];
    send_burst(`PS_CORE_COUNT'(1) << c);
    wait_idle();
    want = {c, slot_no_t'(burst_msg[c][`PS_SLOT_NO_WIDTH-1:0])};
    request_packets(1);
    wait_idle();
    check_desc("release_reuse", want, last_desc);
    finish_test();
  endtask

  task automatic arbitrate_bursts();
    logic [31:0]               r;
    logic [`PS_CORE_COUNT-1:0] mask;
    start_test("arbitration");
    r    = xorshift32();
    mask = r[`PS_CORE_COUNT-1:0];
    if (mask == '0) begin
      mask = `PS_CORE_COUNT'(1);
    end
    send_burst(mask);
    send_burst(mask);
    wait_idle();
    finish_test();
  endtask

  task automatic apply_backpressure();
    start_test("backpressure");
    rx_desc_ready = 1'b0;
    done_ready    = 1'b0;
    pkt_valid     = 1'b1;
    send_burst(`PS_CORE_COUNT'(16'h1224));
    repeat (24) @(negedge logic_clk);
    check_flag("backpressure pkt_ready", 1'b0, pkt_ready);
    check_flag("backpressure rx_desc_valid", 1'b1, rx_desc_valid);
    check_flag("backpressure done_valid", 1'b1, done_valid);
    pkt_valid     = 1'b0;
    rx_desc_ready = 1'b1;
    done_ready    = 1'b1;
    wait_idle();
    finish_test();
  endtask

  initial begin
    logic_clk      = 1'b0;
    arst_n         = 1'b0;
    pkt_valid      = 1'b0;
    rx_desc_ready  = 1'b1;
    core_msg_data  = '0;
    core_msg_valid = '0;
    done_ready     = 1'b1;
    rng_state      = 32'd93;
    cycle_cnt      = 0;
    acc_cnt        = 0;
    pass_cnt       = 0;
    fail_cnt       = 0;
    test_errs      = 0;
    desc_hold      = 1'b0;
    done_hold      = 1'b0;
    done_seen      = 1'b0;
    cur_test       = "reset";
    alloc_last     = core_no_t'(`PS_CORE_COUNT - 1);
    arb_last       = core_no_t'(`PS_CORE_COUNT - 1);
    for (int c = 0; c < `PS_CORE_COUNT; c++) begin
      model_map[c] = '1;
    end
    repeat (16) @(posedge logic_clk);
    @(negedge logic_clk);
    arst_n = 1'b1;
    @(negedge logic_clk);
    verify_reset_state();
    exhaust_slots();
    release_and_reuse();
    arbitrate_bursts();
    apply_backpressure();
    $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: build.f
+incdir+rtl
rtl/pkt_sched_pkg.sv
rtl/core_msg_fifo.sv
rtl/core_msg_arbiter.sv
rtl/slot_tracker.sv
rtl/pkt_sched_top.sv
testbench/tb_pkt_sched.sv
